/* vlog.f */
+incdir+design
design/rice_core_pkg.sv
design/rice_core_if_stage.sv
design/rice_core_id_stage.sv
design/rice_core_register_file.sv
design/rice_core_ex_stage.sv
design/rice_core.sv
verification/rice_core_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/1ps \
  --top-module rice_core_tb -f vlog.f -o rice_core_sim

./obj_dir/rice_core_sim 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi

/* verification/rice_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rice_core_tb;
  localparam logic [31:0] RESET_PC      = 32'h0000_0100;
  localparam int          DRIVE_DELAY   = 1;
  localparam int          N_ENABLE      = 2;
  localparam int          N_IMM         = 11;
  localparam int          N_CHAIN       = 10;
  localparam int          N_X0          = 7;
  localparam int          TIMEOUT_CYCLES  = 7 * (N_ENABLE + N_IMM + 2 * N_CHAIN + N_X0) + 200;
  localparam logic [6:0]  OPC_LUI       = 7'b0110111;
  localparam logic [6:0]  OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0]  OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0]  OPC_OP        = 7'b0110011;
  localparam logic [6:0]  OPC_STORE     = 7'b0100011;
  localparam logic [6:0]  OPC_BRANCH    = 7'b1100011;

  logic         i_clk;
  logic         i_rst_n;
  logic         enable;
  logic         wb_cyc;
  logic         wb_stb;
  logic [31:0]  wb_adr;
  logic [31:0]  wb_dat_r  = '0;
  logic         wb_ack    = 1'b0;
  logic         retire_valid;
  logic [31:0]  retire_pc;
  logic [4:0]   retire_rd;
  logic         retire_write;
  logic [31:0]  retire_value;

  logic [31:0]  imem [64];
  logic [31:0]  prog [$];
  logic [31:0]  model_regs [32];
  logic [31:0]  exp_pc        = RESET_PC;
  logic [4:0]   exp_rd;
  logic         exp_write;
  logic [31:0]  exp_value;
  int           retire_count  = 0;
  int           error_count   = 0;
  int           cycle_count   = 0;
  logic         use_waits;
  logic         busy          = 1'b0;
  logic [1:0]   wait_left     = '0;
  logic [31:0]  rand_state    = 32'd16;

  rice_core #(
    .XLEN     (32       ),
    .RESET_PC (RESET_PC )
  ) i_rice_core (
    .i_clk, .i_rst_n, .enable,
    .wb_cyc, .wb_stb, .wb_adr, .wb_dat_r, .wb_ack,
    .retire_valid, .retire_pc, .retire_rd, .retire_write, .retire_value
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

//----------------------------------------------------------------------------
//  instruction encoding
//----------------------------------------------------------------------------
  function automatic logic [31:0] alu_imm(logic [2:0] funct3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, funct3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] alu_reg(logic [6:0] funct7, logic [2:0] funct3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] upper(logic [6:0] opcode, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opcode};
  endfunction

  function automatic logic [31:0] store_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] branch_equal(logic [4:0] rs1, logic [4:0] rs2,
                                               logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] fill_word(int index);
    return {index[24:0], 7'b0001011};  // custom-0 opcode with no alu op
  endfunction

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

//----------------------------------------------------------------------------
//  reference model and checking
//----------------------------------------------------------------------------
  task automatic predict_retire(input logic [31:0] inst, input logic [31:0] pc,
                                output logic [4:0] rd, output logic write,
                                output logic [31:0] value);
    logic [31:0]  rs1_value;
    logic [31:0]  rs2_value;
    logic [31:0]  imm_i;
    logic [31:0]  imm_u;
    logic         known;
    rs1_value = model_regs[inst[19:15]];
    rs2_value = model_regs[inst[24:20]];
    imm_i     = {{20{inst[31]}}, inst[31:20]};
    imm_u     = {inst[31:12], 12'b0};
    rd        = inst[11:7];
    known     = 1'b1;
    value     = '0;
    case (inst[6:0])
      OPC_LUI:    value = imm_u;
      OPC_AUIPC:  value = pc + imm_u;
      OPC_OP_IMM: begin
        case (inst[14:12])
          3'b000:   value = rs1_value + imm_i;
          3'b111:   value = rs1_value & imm_i;
          3'b110:   value = rs1_value | imm_i;
          3'b100:   value = rs1_value ^ imm_i;
          default:  known = 1'b0;
        endcase
      end
      OPC_OP: begin
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000:  value = rs1_value + rs2_value;
          10'b0100000_000:  value = rs1_value - rs2_value;
          10'b0000000_111:  value = rs1_value & rs2_value;
          10'b0000000_110:  value = rs1_value | rs2_value;
          10'b0000000_100:  value = rs1_value ^ rs2_value;
          default:          known = 1'b0;
        endcase
      end
      default:    known = 1'b0;
    endcase
    if (inst[6:0] == OPC_STORE || inst[6:0] == OPC_BRANCH) begin
      rd = '0;  // s and b formats carry no rd
    end
    write = known && (rd != 5'd0);
  endtask

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, expected);
      stop_on_failure();
    end
  endtask

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: no progress after %0d cycles", cycle_count);
      stop_on_failure();
    end
  end

  // retire monitor with pc stepping by 4 from reset
  always @(posedge i_clk) begin
    #DRIVE_DELAY;
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      exp_pc        = RESET_PC;
      retire_count  = 0;
    end else if (retire_valid) begin
      predict_retire(imem[exp_pc[7:2]], exp_pc, exp_rd, exp_write, exp_value);
      check_value("retire_pc", retire_pc, exp_pc);
      check_value("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd});
      check_value("retire_write", {31'b0, retire_write}, {31'b0, exp_write});
      check_value("retire_value", retire_value, exp_value);
      if (exp_write) begin
        model_regs[exp_rd] = exp_value;
      end
      exp_pc        = exp_pc + 32'd4;
      retire_count  = retire_count + 1;
    end
  end

//----------------------------------------------------------------------------
//  wishbone instruction memory
//----------------------------------------------------------------------------
  always @(posedge i_clk) begin
    #DRIVE_DELAY;
    if (!i_rst_n) begin
      wb_ack    = 1'b0;
      busy      = 1'b0;
      wait_left = '0;
    end else if (wb_ack) begin
      check_value("wb_cyc", {31'b0, wb_cyc}, 32'd0);  // cycle ends after ack
      check_value("wb_stb", {31'b0, wb_stb}, 32'd0);
      wb_ack = 1'b0;  // single-cycle ack
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy        = 1'b1;
        rand_state  = xorshift32(rand_state);
        wait_left   = use_waits ? rand_state[1:0] : 2'd0;
      end
      if (wait_left == 2'd0) begin
        wb_dat_r  = imem[wb_adr[7:2]];
        wb_ack    = 1'b1;
        busy      = 1'b0;
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

//----------------------------------------------------------------------------
//  directed tests
//----------------------------------------------------------------------------
  task automatic start_program(input logic en, input logic waits);
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_rst_n   = 1'b0;
    enable    = en;
    use_waits = waits;
    for (int i = 0; i < 64; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
    end
    repeat (3) @(posedge i_clk);
    #DRIVE_DELAY;
    i_rst_n = 1'b1;
  endtask

  task automatic wait_retired(input int count);
    while (retire_count < count) begin
      @(negedge i_clk);
    end
  endtask

  task automatic gate_fetch_on_enable();
    prog.delete();
    prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, 12'd5));
    prog.push_back(alu_imm(3'b000, 5'd2, 5'd1, -12'sd3));
    start_program(1'b0, 1'b0);
    repeat (20) begin
      @(negedge i_clk);
      check_value("wb_cyc", {31'b0, wb_cyc}, 32'd0);
      check_value("wb_stb", {31'b0, wb_stb}, 32'd0);
      check_value("retire_valid", {31'b0, retire_valid}, 32'd0);
    end
    @(posedge i_clk);
    #DRIVE_DELAY;
    enable = 1'b1;
    while (!wb_cyc) begin
      @(negedge i_clk);
    end
    check_value("wb_stb", {31'b0, wb_stb}, 32'd1);
    check_value("wb_adr", wb_adr, RESET_PC);  // first fetch
    wait_retired(prog.size());
  endtask

  task automatic exercise_immediates();
    prog.delete();
    prog.push_back(upper(OPC_LUI, 5'd1, 20'h12345));
    prog.push_back(upper(OPC_LUI, 5'd2, 20'hfffff));
    prog.push_back(upper(OPC_AUIPC, 5'd3, 20'h00010));
    prog.push_back(upper(OPC_AUIPC, 5'd4, 20'h80000));
    prog.push_back(alu_imm(3'b000, 5'd5, 5'd1, 12'h7ff));
    prog.push_back(alu_imm(3'b000, 5'd6, 5'd5, 12'h800));  // -2048
    prog.push_back(alu_imm(3'b111, 5'd7, 5'd2, -12'sd16));
    prog.push_back(alu_imm(3'b110, 5'd8, 5'd1, 12'h0f0));
    prog.push_back(alu_imm(3'b100, 5'd9, 5'd6, -12'sd1));
    prog.push_back(alu_imm(3'b111, 5'd10, 5'd9, 12'h555));
    prog.push_back(alu_imm(3'b000, 5'd11, 5'd0, -12'sd1));
    start_program(1'b1, 1'b0);
    wait_retired(prog.size());
  endtask

  task automatic chain_dependent_ops(input logic waits);
    prog.delete();
    prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, 12'd100));
    prog.push_back(alu_imm(3'b000, 5'd2, 5'd0, -12'sd7));
    prog.push_back(alu_reg(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
    prog.push_back(alu_reg(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1));
    prog.push_back(alu_reg(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd3));
    prog.push_back(alu_reg(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd2));
    prog.push_back(alu_reg(7'b0000000, 3'b100, 5'd7, 5'd6, 5'd4));
    prog.push_back(alu_reg(7'b0000000, 3'b000, 5'd7, 5'd7, 5'd7));
    prog.push_back(alu_reg(7'b0100000, 3'b000, 5'd8, 5'd7, 5'd2));
    prog.push_back(alu_reg(7'b0000000, 3'b100, 5'd9, 5'd8, 5'd7));
    start_program(1'b1, waits);
    wait_retired(prog.size());
  endtask

  task automatic retire_x0_and_unsupported();
    prog.delete();
    prog.push_back(alu_imm(3'b000, 5'd0, 5'd0, 12'd55));  // x0 stays zero
    prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, 12'd9));
    prog.push_back(store_word(5'd1, 5'd2, 12'd8));       // rd field holds 8
    prog.push_back(branch_equal(5'd1, 5'd1, 13'd12));    // rd field holds 12
    prog.push_back(alu_reg(7'b0000000, 3'b000, 5'd3, 5'd0, 5'd1));
    prog.push_back(alu_reg(7'b0000000, 3'b000, 5'd4, 5'd8, 5'd12));
    prog.push_back(alu_imm(3'b100, 5'd5, 5'd0, 12'd3));
    start_program(1'b1, 1'b0);
    wait_retired(prog.size());
  endtask

  initial begin
    i_rst_n   = 1'b0;
    enable    = 1'b0;
    use_waits = 1'b0;
    gate_fetch_on_enable();
    exercise_immediates();
    chain_dependent_ops(1'b0);
    chain_dependent_ops(1'b1);  // random wait states
    retire_x0_and_unsupported();
    if (error_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_on_failure();
    end
  end
endmodule

`default_nettype wire

/* design/rice_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rice_core_macros.svh"

module rice_core #(
  parameter int               XLEN      = 32,
  parameter logic [XLEN-1:0]  RESET_PC  = '0
)(
  input   var logic                         i_clk,
  input   var logic                         i_rst_n,
  input   var logic                         enable,
  output  logic                             wb_cyc,
  output  logic                             wb_stb,
  output  logic [XLEN-1:0]                  wb_adr,
  input   var rice_core_pkg::rice_core_inst wb_dat_r,
  input   var logic                         wb_ack,
  output  logic                             retire_valid,
  output  logic [XLEN-1:0]                  retire_pc,
  output  rice_core_pkg::rice_core_rd       retire_rd,
  output  logic                             retire_write,
  output  logic [XLEN-1:0]                  retire_value
);
  import  rice_core_pkg::*;
  `rice_core_define_types(XLEN)

  logic                   if_valid;
  rice_core_pc            if_pc;
  rice_core_inst          if_inst;
  logic                   id_valid;
  rice_core_pc            id_pc;
  rice_core_rd            id_rd;
  rice_core_value         id_rs1_value;
  rice_core_value         id_rs2_value;
  rice_core_value         id_imm_value;
  rice_core_alu_command   id_alu_command;
  rice_core_alu_source    id_alu_source_1;
  rice_core_alu_source    id_alu_source_2;
  logic                   wb_write;
  rice_core_rd            wb_rd;
  rice_core_value         wb_value;
  rice_core_value [31:0]  register_file;

  rice_core_if_stage #(
    .XLEN     (XLEN     ),
    .RESET_PC (RESET_PC )
  ) u_if_stage (
    .i_clk, .i_rst_n, .enable,
    .wb_cyc, .wb_stb, .wb_adr, .wb_dat_r, .wb_ack,
    .if_valid, .if_pc, .if_inst
  );

  rice_core_id_stage #(
    .XLEN (XLEN )
  ) u_id_stage (
    .i_clk, .i_rst_n, .enable,
    .if_valid, .if_pc, .if_inst,
    .register_file,
    .wb_write, .wb_rd, .wb_value,
    .id_valid, .id_pc, .id_rd,
    .id_rs1_value, .id_rs2_value, .id_imm_value,
    .id_alu_command, .id_alu_source_1, .id_alu_source_2
  );

  rice_core_ex_stage #(
    .XLEN (XLEN )
  ) u_ex_stage (
    .i_clk, .i_rst_n,
    .id_valid, .id_pc, .id_rd,
    .id_rs1_value, .id_rs2_value, .id_imm_value,
    .id_alu_command, .id_alu_source_1, .id_alu_source_2,
    .wb_write, .wb_rd, .wb_value,
    .retire_valid, .retire_pc, .retire_rd, .retire_write, .retire_value
  );

  rice_core_register_file #(
    .XLEN (XLEN )
  ) u_register_file (
    .i_clk, .i_rst_n,
    .wb_write, .wb_rd, .wb_value,
    .register_file
  );
endmodule

`default_nettype wire

/* design/rice_core_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rice_core_macros.svh"

module rice_core_ex_stage #(
  parameter int XLEN  = 32
)(
  input   var logic                                 i_clk,
  input   var logic                                 i_rst_n,
  input   var logic                                 id_valid,
  input   var logic [XLEN-1:0]                      id_pc,
  input   var rice_core_pkg::rice_core_rd           id_rd,
  input   var logic [XLEN-1:0]                      id_rs1_value,
  input   var logic [XLEN-1:0]                      id_rs2_value,
  input   var logic [XLEN-1:0]                      id_imm_value,
  input   var rice_core_pkg::rice_core_alu_command  id_alu_command,
  input   var rice_core_pkg::rice_core_alu_source   id_alu_source_1,
  input   var rice_core_pkg::rice_core_alu_source   id_alu_source_2,
  output  logic                                     wb_write,
  output  rice_core_pkg::rice_core_rd               wb_rd,
  output  logic [XLEN-1:0]                          wb_value,
  output  logic                                     retire_valid,
  output  logic [XLEN-1:0]                          retire_pc,
  output  rice_core_pkg::rice_core_rd               retire_rd,
  output  logic                                     retire_write,
  output  logic [XLEN-1:0]                          retire_value
);
  import  rice_core_pkg::*;
  `rice_core_define_types(XLEN)

  rice_core_value operand_1;
  rice_core_value operand_2;

  function automatic rice_core_value select_operand(
    rice_core_alu_source  source,
    rice_core_value       rs_value
  );
    case (source)
      RICE_CORE_ALU_SOURCE_RS:  return rs_value;
      RICE_CORE_ALU_SOURCE_IMM: return id_imm_value;
      RICE_CORE_ALU_SOURCE_PC:  return id_pc;
      default:                  return '0;
    endcase
  endfunction

  always_comb begin
    operand_1 = select_operand(id_alu_source_1, id_rs1_value);
    operand_2 = select_operand(id_alu_source_2, id_rs2_value);
    case (id_alu_command)
      RICE_CORE_ALU_ADD:  wb_value  = operand_1 + operand_2;
      RICE_CORE_ALU_SUB:  wb_value  = operand_1 - operand_2;
      RICE_CORE_ALU_AND:  wb_value  = operand_1 & operand_2;
      RICE_CORE_ALU_OR:   wb_value  = operand_1 | operand_2;
      RICE_CORE_ALU_XOR:  wb_value  = operand_1 ^ operand_2;
      default:            wb_value  = '0;
    endcase
  end

  assign  wb_write  = id_valid && (id_alu_command != RICE_CORE_ALU_NONE) && (id_rd != '0);
  assign  wb_rd     = id_rd;

//----------------------------------------------------------------------------
//  retire trace
//----------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      retire_valid  <= 1'b0;
      retire_write  <= 1'b0;
    end else begin
      retire_valid  <= id_valid;
      retire_write  <= wb_write;  // same edge as the register write
    end
  end

  always_ff @(posedge i_clk) begin
    if (id_valid) begin
      retire_pc     <= id_pc;
      retire_rd     <= id_rd;
      retire_value  <= wb_value;
    end
  end
endmodule

`default_nettype wire

/* design/rice_core_register_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rice_core_macros.svh"

module rice_core_register_file #(
  parameter int XLEN  = 32
)(
  input   var logic                       i_clk,
  input   var logic                       i_rst_n,
  input   var logic                       wb_write,
  input   var rice_core_pkg::rice_core_rd wb_rd,
  input   var logic [XLEN-1:0]            wb_value,
  output  logic [31:0][XLEN-1:0]          register_file
);
  `rice_core_define_types(XLEN)

  rice_core_value [31:1]  registers;  // x0 has no storage

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      registers <= '0;
    end else begin
      for (int i = 1; i < 32; i++) begin
        if (wb_write && (int'(wb_rd) == i)) begin
          registers[i]  <= wb_value;
        end
      end
    end
  end

  assign  register_file = {registers, rice_core_value'(0)};
endmodule

`default_nettype wire

/* design/rice_core_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rice_core_macros.svh"

module rice_core_id_stage #(
  parameter int XLEN  = 32
)(
  input   var logic                                 i_clk,
  input   var logic                                 i_rst_n,
  input   var logic                                 enable,
  input   var logic                                 if_valid,
  input   var logic [XLEN-1:0]                      if_pc,
  input   var rice_core_pkg::rice_core_inst         if_inst,
  input   var logic [31:0][XLEN-1:0]                register_file,
  input   var logic                                 wb_write,
  input   var rice_core_pkg::rice_core_rd           wb_rd,
  input   var logic [XLEN-1:0]                      wb_value,
  output  logic                                     id_valid,
  output  logic [XLEN-1:0]                          id_pc,
  output  rice_core_pkg::rice_core_rd               id_rd,
  output  logic [XLEN-1:0]                          id_rs1_value,
  output  logic [XLEN-1:0]                          id_rs2_value,
  output  logic [XLEN-1:0]                          id_imm_value,
  output  rice_core_pkg::rice_core_alu_command      id_alu_command,
  output  rice_core_pkg::rice_core_alu_source       id_alu_source_1,
  output  rice_core_pkg::rice_core_alu_source       id_alu_source_2
);
  import  rice_core_pkg::*;
  `rice_core_define_types(XLEN)

  rice_core_alu_command alu_command;
  rice_core_alu_source  alu_source_1;
  rice_core_alu_source  alu_source_2;

  function automatic rice_core_rd decode_rd(rice_core_inst inst);
    case (get_inst_type(get_opcode(inst)))
      RICE_CORE_INST_TYPE_S,
      RICE_CORE_INST_TYPE_B:  return '0;
      default:                return get_rd(inst);
    endcase
  endfunction

  function automatic rice_core_value read_operand(rice_core_rs rs);
    if (wb_write && (wb_rd == rs)) begin
      return wb_value;              // written on this same edge
    end
    return register_file[rs];
  endfunction

  function automatic rice_core_value get_imm_value(rice_core_inst inst);
    case (get_inst_type(get_opcode(inst)))
      RICE_CORE_INST_TYPE_I:
        return {{(XLEN-11){inst[31]}}, inst[30:20]};
      RICE_CORE_INST_TYPE_S:
        return {{(XLEN-11){inst[31]}}, inst[30:25], inst[11:7]};
      RICE_CORE_INST_TYPE_B:
        return {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      RICE_CORE_INST_TYPE_U:
        return {{(XLEN-31){inst[31]}}, inst[30:12], 12'b0};
      RICE_CORE_INST_TYPE_J:
        return {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        return '0;                  // r-type has none
    endcase
  endfunction

//----------------------------------------------------------------------------
//  alu operation
//----------------------------------------------------------------------------
  always_comb begin
    alu_command   = RICE_CORE_ALU_NONE;
    alu_source_1  = RICE_CORE_ALU_SOURCE_IMM_0;
    alu_source_2  = RICE_CORE_ALU_SOURCE_IMM_0;
    case (get_opcode(if_inst))
      RICE_CORE_OPCODE_LUI: begin
        alu_command   = RICE_CORE_ALU_ADD;  // 0 + imm
        alu_source_2  = RICE_CORE_ALU_SOURCE_IMM;
      end
      RICE_CORE_OPCODE_AUIPC: begin
        alu_command   = RICE_CORE_ALU_ADD;
        alu_source_1  = RICE_CORE_ALU_SOURCE_PC;
        alu_source_2  = RICE_CORE_ALU_SOURCE_IMM;
      end
      RICE_CORE_OPCODE_OP_IMM: begin
        case (get_funct3(if_inst))
          3'b000:   alu_command = RICE_CORE_ALU_ADD;
          3'b111:   alu_command = RICE_CORE_ALU_AND;
          3'b110:   alu_command = RICE_CORE_ALU_OR;
          3'b100:   alu_command = RICE_CORE_ALU_XOR;
          default:  alu_command = RICE_CORE_ALU_NONE;  // shifts, slti
        endcase
        if (alu_command != RICE_CORE_ALU_NONE) begin
          alu_source_1  = RICE_CORE_ALU_SOURCE_RS;
          alu_source_2  = RICE_CORE_ALU_SOURCE_IMM;
        end
      end
      RICE_CORE_OPCODE_OP: begin
        case ({get_funct7(if_inst), get_funct3(if_inst)})
          10'b0000000_000:  alu_command = RICE_CORE_ALU_ADD;
          10'b0100000_000:  alu_command = RICE_CORE_ALU_SUB;
          10'b0000000_111:  alu_command = RICE_CORE_ALU_AND;
          10'b0000000_110:  alu_command = RICE_CORE_ALU_OR;
          10'b0000000_100:  alu_command = RICE_CORE_ALU_XOR;
          default:          alu_command = RICE_CORE_ALU_NONE;
        endcase
        if (alu_command != RICE_CORE_ALU_NONE) begin
          alu_source_1  = RICE_CORE_ALU_SOURCE_RS;
          alu_source_2  = RICE_CORE_ALU_SOURCE_RS;
        end
      end
      default: begin
      end
    endcase
  end

//----------------------------------------------------------------------------
//  decode register
//----------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      id_valid        <= 1'b0;
      id_pc           <= '0;
      id_rd           <= '0;
      id_rs1_value    <= '0;
      id_rs2_value    <= '0;
      id_imm_value    <= '0;
      id_alu_command  <= RICE_CORE_ALU_NONE;
      id_alu_source_1 <= RICE_CORE_ALU_SOURCE_IMM_0;
      id_alu_source_2 <= RICE_CORE_ALU_SOURCE_IMM_0;
    end else if (!enable) begin
      id_valid        <= 1'b0;
      id_pc           <= '0;
      id_rd           <= '0;
      id_rs1_value    <= '0;
      id_rs2_value    <= '0;
      id_imm_value    <= '0;
      id_alu_command  <= RICE_CORE_ALU_NONE;
      id_alu_source_1 <= RICE_CORE_ALU_SOURCE_IMM_0;
      id_alu_source_2 <= RICE_CORE_ALU_SOURCE_IMM_0;
    end else begin
      id_valid  <= if_valid;
      if (if_valid) begin
        id_pc           <= if_pc;
        id_rd           <= decode_rd(if_inst);
        id_rs1_value    <= read_operand(get_rs1(if_inst));
        id_rs2_value    <= read_operand(get_rs2(if_inst));
        id_imm_value    <= get_imm_value(if_inst);
        id_alu_command  <= alu_command;
        id_alu_source_1 <= alu_source_1;
        id_alu_source_2 <= alu_source_2;
      end
    end
  end
endmodule

`default_nettype wire

/* design/rice_core_if_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rice_core_macros.svh"

module rice_core_if_stage #(
  parameter int               XLEN      = 32,
  parameter logic [XLEN-1:0]  RESET_PC  = '0
)(
  input   var logic                         i_clk,
  input   var logic                         i_rst_n,
  input   var logic                         enable,
  output  logic                             wb_cyc,
  output  logic                             wb_stb,
  output  logic [XLEN-1:0]                  wb_adr,
  input   var rice_core_pkg::rice_core_inst wb_dat_r,
  input   var logic                         wb_ack,
  output  logic                             if_valid,
  output  logic [XLEN-1:0]                  if_pc,
  output  rice_core_pkg::rice_core_inst     if_inst
);
  `rice_core_define_types(XLEN)

  typedef enum logic {
    IDLE,
    WAIT_ACK
  } fetch_state;

  fetch_state   state;
  rice_core_pc  pc;

  assign  wb_cyc  = state == WAIT_ACK;
  assign  wb_stb  = state == WAIT_ACK;
  assign  wb_adr  = pc;               // held until ack

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= IDLE;
      pc        <= RESET_PC;
      if_valid  <= 1'b0;
    end else begin
      if_valid  <= 1'b0;
      case (state)
        IDLE: begin
          if (enable) begin
            state <= WAIT_ACK;
          end
        end
        default: begin
          if (wb_ack) begin
            state     <= IDLE;
            pc        <= pc + XLEN'(4);
            if_valid  <= enable;      // dropped when disabled
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (wb_cyc && wb_ack) begin
      if_pc   <= pc;
      if_inst <= wb_dat_r;
    end
  end
endmodule

`default_nettype wire

/* design/rice_core_pkg.sv */
`default_nettype none

package rice_core_pkg;
  typedef logic [31:0]  rice_core_inst;
  typedef logic [4:0]   rice_core_rs;
  typedef logic [4:0]   rice_core_rd;
  typedef logic [2:0]   rice_core_funct3;
  typedef logic [6:0]   rice_core_funct7;

  typedef enum logic [6:0] {
    RICE_CORE_OPCODE_LUI    = 7'b0110111,
    RICE_CORE_OPCODE_AUIPC  = 7'b0010111,
    RICE_CORE_OPCODE_OP_IMM = 7'b0010011,
    RICE_CORE_OPCODE_OP     = 7'b0110011,
    RICE_CORE_OPCODE_LOAD   = 7'b0000011,
    RICE_CORE_OPCODE_STORE  = 7'b0100011,
    RICE_CORE_OPCODE_BRANCH = 7'b1100011,
    RICE_CORE_OPCODE_JAL    = 7'b1101111,
    RICE_CORE_OPCODE_JALR   = 7'b1100111
  } rice_core_opcode;

  typedef enum logic [2:0] {
    RICE_CORE_INST_TYPE_R,
    RICE_CORE_INST_TYPE_I,
    RICE_CORE_INST_TYPE_S,
    RICE_CORE_INST_TYPE_B,
    RICE_CORE_INST_TYPE_U,
    RICE_CORE_INST_TYPE_J
  } rice_core_inst_type;

  typedef enum logic [2:0] {
    RICE_CORE_ALU_NONE,
    RICE_CORE_ALU_ADD,
    RICE_CORE_ALU_SUB,
    RICE_CORE_ALU_AND,
    RICE_CORE_ALU_OR,
    RICE_CORE_ALU_XOR
  } rice_core_alu_command;

  typedef enum logic [1:0] {
    RICE_CORE_ALU_SOURCE_RS,
    RICE_CORE_ALU_SOURCE_IMM,
    RICE_CORE_ALU_SOURCE_IMM_0,
    RICE_CORE_ALU_SOURCE_PC
  } rice_core_alu_source;

//----------------------------------------------------------------------------
//  field extraction
//----------------------------------------------------------------------------
  function automatic rice_core_opcode get_opcode(rice_core_inst inst);
    return rice_core_opcode'(inst[6:0]);  // may hold an unlisted value
  endfunction

  function automatic rice_core_funct3 get_funct3(rice_core_inst inst);
    return inst[14:12];
  endfunction

  function automatic rice_core_funct7 get_funct7(rice_core_inst inst);
    return inst[31:25];
  endfunction

  function automatic rice_core_rs get_rs1(rice_core_inst inst);
    return inst[19:15];
  endfunction

  function automatic rice_core_rs get_rs2(rice_core_inst inst);
    return inst[24:20];
  endfunction

  function automatic rice_core_rd get_rd(rice_core_inst inst);
    return inst[11:7];
  endfunction

  function automatic rice_core_inst_type get_inst_type(rice_core_opcode opcode);
    case (opcode)
      RICE_CORE_OPCODE_LUI,
      RICE_CORE_OPCODE_AUIPC:   return RICE_CORE_INST_TYPE_U;
      RICE_CORE_OPCODE_OP_IMM,
      RICE_CORE_OPCODE_LOAD,
      RICE_CORE_OPCODE_JALR:    return RICE_CORE_INST_TYPE_I;
      RICE_CORE_OPCODE_STORE:   return RICE_CORE_INST_TYPE_S;
      RICE_CORE_OPCODE_BRANCH:  return RICE_CORE_INST_TYPE_B;
      RICE_CORE_OPCODE_JAL:     return RICE_CORE_INST_TYPE_J;
      default:                  return RICE_CORE_INST_TYPE_R;
    endcase
  endfunction
endpackage

`default_nettype wire

/* design/rice_core_macros.svh */
`ifndef RICE_CORE_MACROS_SVH
`define RICE_CORE_MACROS_SVH

// xlen-wide types declared inside each module that needs them
`define rice_core_define_types(xlen) \
  typedef logic [xlen-1:0]  rice_core_value; \
  typedef logic [xlen-1:0]  rice_core_pc;

`endif
